// File: design/load_sequencer.sv
`timescale 1ns/1ps

module load_sequencer (
	input  logic                 i_sclk,
	input  logic                 i_rstp,

	input  logic                 i_valid,
	output logic                 o_ready,

	input  logic                 i_predict_vld,
	input  stream_pkg::predict_t i_predict,

	input  logic                 i_ready,
	output logic                 o_valid,
	output stream_pkg::predict_t o_tdata,

	word_tag_if.seq              tag
);

	section_pkg::section_t section_q;
	section_pkg::count_t   count_q;
	section_pkg::count_t   last_count;
	logic                  half_q;
	logic                  wait_q;
	logic                  ready_q;
	logic                  valid_q;
	stream_pkg::predict_t  result_q;

	logic                  accept;
	logic                  wide;
	logic                  last_word;
	logic                  predict_take;

	assign accept       = i_valid & ready_q;
	assign wide         = section_pkg::section_is_wide(section_q);
	assign last_count   = section_pkg::section_len(section_q) - 1'b1;
	assign predict_take = wait_q & i_predict_vld;    // pulses outside the wait are dropped.

	// a wide section ends on the second half of its last pair.
	assign last_word = (count_q == last_count) && (!wide || half_q);

	// classification uses the state current at the handshake.
	assign tag.tag_vld     = accept;
	assign tag.tag_section = section_q;
	assign tag.tag_wide    = wide;
	assign tag.tag_second  = half_q;

	always_ff @(posedge i_sclk)
	begin
		if (i_rstp)
		begin
			section_q <= '0;
			count_q   <= '0;
			half_q    <= 1'b0;
			wait_q    <= 1'b0;
			ready_q   <= 1'b0;
		end
		else if (accept)
		begin
			if (last_word)
			begin
				count_q <= '0;
				half_q  <= 1'b0;
				if (section_q == section_pkg::IMAGE_SECTION)
				begin
					wait_q  <= 1'b1;    // input closes until the prediction.
					ready_q <= 1'b0;
				end
				else
				begin
					section_q <= section_q + 1'b1;
				end
			end
			else if (wide)
			begin
				half_q <= ~half_q;
				if (half_q)
				begin
					count_q <= count_q + 1'b1;
				end
			end
			else
			begin
				count_q <= count_q + 1'b1;
			end
		end
		else if (predict_take)
		begin
			// reload the image only, weights stay in place.
			section_q <= section_pkg::IMAGE_SECTION;
			count_q   <= '0;
			half_q    <= 1'b0;
			wait_q    <= 1'b0;
			ready_q   <= 1'b1;
		end
		else if (!wait_q)
		begin
			ready_q <= 1'b1;
		end
	end

	// result register, a new prediction wins over an accept on the same edge.
	always_ff @(posedge i_sclk)
	begin
		if (i_rstp)
		begin
			valid_q <= 1'b0;
		end
		else if (predict_take)
		begin
			valid_q <= 1'b1;
		end
		else if (valid_q && i_ready)
		begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (predict_take)
		begin
			result_q <= i_predict;
		end
	end

	assign o_ready = ready_q;
	assign o_valid = valid_q;
	assign o_tdata = result_q;

endmodule

// File: design/param_decode_cfg.svh
`ifndef PARAM_DECODE_CFG_SVH
`define PARAM_DECODE_CFG_SVH

// stream widths.
`define PD_WORD_W       32
`define PD_PREDICT_W    10

// section table layout.
`define PD_NUM_SECTIONS 7
`define PD_NUM_WIDE     3

// wide sections, length counted in 64-bit parameters (two words each).
`define PD_LEN_S0       6
`define PD_LEN_S1       4
`define PD_LEN_S2       4

// narrow sections, one word per parameter.
`define PD_LEN_S3       5
`define PD_LEN_S4       3
`define PD_LEN_S5       7

// image section, always the last one.
`define PD_LEN_S6       9

`endif

// File: design/param_decode_top.sv
`timescale 1ns/1ps

module param_decode_top (
	input  logic                 i_sclk,
	input  logic                 i_rstp,

	input  logic                 i_valid,
	input  stream_pkg::word_t    i_tdata,
	output logic                 o_ready,

	input  logic                 i_predict_vld,
	input  stream_pkg::predict_t i_predict,

	input  logic                 i_ready,
	output logic                 o_valid,
	output stream_pkg::predict_t o_tdata,

	output section_pkg::strobe_t o_param_vld,
	output stream_pkg::param_t   o_param
);

	logic                  beat_vld;
	section_pkg::section_t beat_section;
	stream_pkg::param_t    beat_data;

	word_tag_if u_tag ();

	load_sequencer u_load_sequencer (
		.i_sclk        (i_sclk),
		.i_rstp        (i_rstp),
		.i_valid       (i_valid),
		.o_ready       (o_ready),
		.i_predict_vld (i_predict_vld),
		.i_predict     (i_predict),
		.i_ready       (i_ready),
		.o_valid       (o_valid),
		.o_tdata       (o_tdata),
		.tag           (u_tag.seq)
	);

	word_assembler u_word_assembler (
		.i_sclk         (i_sclk),
		.i_rstp         (i_rstp),
		.i_tdata        (i_tdata),
		.tag            (u_tag.asm),
		.o_beat_vld     (beat_vld),
		.o_beat_section (beat_section),
		.o_beat_data    (beat_data)
	);

	param_emitter u_param_emitter (
		.i_sclk         (i_sclk),
		.i_rstp         (i_rstp),
		.i_beat_vld     (beat_vld),
		.i_beat_section (beat_section),
		.i_beat_data    (beat_data),
		.o_param_vld    (o_param_vld),
		.o_param        (o_param)
	);

endmodule

// File: design/param_emitter.sv
`timescale 1ns/1ps

module param_emitter (
	input  logic                  i_sclk,
	input  logic                  i_rstp,

	input  logic                  i_beat_vld,
	input  section_pkg::section_t i_beat_section,
	input  stream_pkg::param_t    i_beat_data,

	output section_pkg::strobe_t  o_param_vld,
	output stream_pkg::param_t    o_param
);

	section_pkg::strobe_t strobe;

	always_comb
	begin
		strobe = '0;
		if (i_beat_vld)
		begin
			strobe[i_beat_section] = 1'b1;    // one bit per section.
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (i_rstp)
		begin
			o_param_vld <= '0;
		end
		else
		begin
			o_param_vld <= strobe;
		end
	end

	// parameter holds until the next beat.
	always_ff @(posedge i_sclk)
	begin
		if (i_beat_vld)
		begin
			o_param <= i_beat_data;
		end
	end

endmodule

// File: design/section_pkg.sv
package section_pkg;

	`include "param_decode_cfg.svh"

	typedef logic [$clog2(`PD_NUM_SECTIONS)-1:0] section_t;
	typedef logic [`PD_NUM_SECTIONS-1:0]         strobe_t;
	typedef logic [3:0]                          count_t;    // longest section is 9.

	localparam section_t IMAGE_SECTION = section_t'(`PD_NUM_SECTIONS - 1);

	// parameter count of a section.
	function automatic count_t section_len(input section_t sec);
		count_t len;
		case (sec)
			section_t'(0): len = count_t'(`PD_LEN_S0);
			section_t'(1): len = count_t'(`PD_LEN_S1);
			section_t'(2): len = count_t'(`PD_LEN_S2);
			section_t'(3): len = count_t'(`PD_LEN_S3);
			section_t'(4): len = count_t'(`PD_LEN_S4);
			section_t'(5): len = count_t'(`PD_LEN_S5);
			section_t'(6): len = count_t'(`PD_LEN_S6);
			default:       len = count_t'(1);
		endcase
		return len;
	endfunction

	// leading sections pack two words per parameter.
	function automatic logic section_is_wide(input section_t sec);
		logic wide;
		wide = (int'(sec) < `PD_NUM_WIDE);
		return wide;
	endfunction

endpackage

// File: design/stream_pkg.sv
package stream_pkg;

	`include "param_decode_cfg.svh"

	// one word of the input stream.
	typedef logic [`PD_WORD_W-1:0] word_t;

	// one parameter, wide enough for a packed pair of words.
	typedef logic [2*`PD_WORD_W-1:0] param_t;

	// class index returned by the accelerator.
	typedef logic [`PD_PREDICT_W-1:0] predict_t;

endpackage

// File: design/word_assembler.sv
`timescale 1ns/1ps

module word_assembler (
	input  logic                  i_sclk,
	input  logic                  i_rstp,

	input  stream_pkg::word_t     i_tdata,
	word_tag_if.asm               tag,

	output logic                  o_beat_vld,
	output section_pkg::section_t o_beat_section,
	output stream_pkg::param_t    o_beat_data
);

	stream_pkg::word_t     word_q;
	stream_pkg::word_t     upper_q;
	logic                  vld_q;
	section_pkg::section_t section_q;
	logic                  wide_q;
	logic                  second_q;

	// capture stage, word and its tag on the handshake edge.
	always_ff @(posedge i_sclk)
	begin
		if (i_rstp)
		begin
			vld_q <= 1'b0;
		end
		else
		begin
			vld_q <= tag.tag_vld;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (tag.tag_vld)
		begin
			word_q    <= i_tdata;
			section_q <= tag.tag_section;
			wide_q    <= tag.tag_wide;
			second_q  <= tag.tag_second;
		end
		if (tag.tag_vld && tag.tag_wide && !tag.tag_second)
		begin
			upper_q <= i_tdata;    // first word of a pair goes on top.
		end
	end

	// beat stage, a first half never produces a beat.
	always_ff @(posedge i_sclk)
	begin
		if (i_rstp)
		begin
			o_beat_vld <= 1'b0;
		end
		else
		begin
			o_beat_vld <= vld_q && (!wide_q || second_q);
		end
	end

	always_ff @(posedge i_sclk)
	begin
		o_beat_section <= section_q;
		o_beat_data    <= wide_q ? {upper_q, word_q} : stream_pkg::param_t'(word_q);
	end

endmodule

// File: design/word_tag_if.sv
`timescale 1ns/1ps

interface word_tag_if;

	logic                  tag_vld;        // word accepted this cycle.
	section_pkg::section_t tag_section;
	logic                  tag_wide;
	logic                  tag_second;     // second half of a wide pair.

	modport seq (
		output tag_vld,
		output tag_section,
		output tag_wide,
		output tag_second
	);

	modport asm (
		input  tag_vld,
		input  tag_section,
		input  tag_wide,
		input  tag_second
	);

endinterface

// File: param_decode.f
+incdir+design
design/stream_pkg.sv
design/section_pkg.sv
design/word_tag_if.sv
design/load_sequencer.sv
design/word_assembler.sv
design/param_emitter.sv
design/param_decode_top.sv
verif/param_decode_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the param_decode testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f param_decode.f \
	--top-module param_decode_tb \
	-o param_decode_sim

out=$(./obj_dir/param_decode_sim)
echo "$out"

if grep -qx '>>> PASS' <<< "$out"
then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// File: verif/param_decode_tb.sv
`timescale 1ns/1ps
`include "param_decode_cfg.svh"

module param_decode_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_GAP      = 3;    // idle cycles before a word.
	localparam int MAX_DELAY    = 8;    // cycles before a prediction pulse.
	localparam int MAX_HOLD     = 4;    // cycles of result back-pressure.
	localparam int IMAGE        = `PD_NUM_SECTIONS - 1;
	localparam int SEC_LEN [`PD_NUM_SECTIONS] = '{`PD_LEN_S0, `PD_LEN_S1, `PD_LEN_S2,
		`PD_LEN_S3, `PD_LEN_S4, `PD_LEN_S5, `PD_LEN_S6};
	localparam int TOTAL_WORDS  = 2 * (`PD_LEN_S0 + `PD_LEN_S1 + `PD_LEN_S2)
		+ `PD_LEN_S3 + `PD_LEN_S4 + `PD_LEN_S5 + 3 * `PD_LEN_S6;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_WORDS * (MAX_GAP + 1)
		+ 3 * (MAX_DELAY + MAX_HOLD) + 200;
	localparam section_pkg::strobe_t WIDE_MASK = section_pkg::strobe_t'((1 << `PD_NUM_WIDE) - 1);
	localparam section_pkg::strobe_t IMAGE_STROBE = section_pkg::strobe_t'(1 << IMAGE);

	localparam int T_RESET   = 0;
	localparam int T_WIDE    = 1;
	localparam int T_NARROW  = 2;
	localparam int T_WAIT    = 3;
	localparam int T_RESULT  = 4;
	localparam int T_RELOAD  = 5;
	localparam int NUM_TESTS = 6;

	logic                 i_sclk;
	logic                 i_rstp;
	logic                 i_valid;
	stream_pkg::word_t    i_tdata;
	logic                 o_ready;
	logic                 i_predict_vld;
	stream_pkg::predict_t i_predict;
	logic                 i_ready;
	logic                 o_valid;
	stream_pkg::predict_t o_tdata;
	section_pkg::strobe_t o_param_vld;
	stream_pkg::param_t   o_param;

	integer               seed;
	int                   cur_test;
	logic                 reload_phase;
	int                   test_errs [NUM_TESTS] = '{default: 0};
	string                test_name [NUM_TESTS] = '{"reset", "wide packing", "narrow sections",
		"inference wait", "result port", "image reload"};
	int                   tests_passed;
	int                   tests_failed;
	int                   seen_cnt [`PD_NUM_SECTIONS] = '{default: 0};

	// reference model state, one expected entry per finished parameter.
	int                   m_sec;
	int                   m_cnt;
	logic                 m_half;
	stream_pkg::word_t    m_upper;
	logic                 model_wait;
	section_pkg::strobe_t exp_strobe_q [$];
	stream_pkg::param_t   exp_param_q [$];

	param_decode_top DUT (
		.i_sclk        (i_sclk),
		.i_rstp        (i_rstp),
		.i_valid       (i_valid),
		.i_tdata       (i_tdata),
		.o_ready       (o_ready),
		.i_predict_vld (i_predict_vld),
		.i_predict     (i_predict),
		.i_ready       (i_ready),
		.o_valid       (o_valid),
		.o_tdata       (o_tdata),
		.o_param_vld   (o_param_vld),
		.o_param       (o_param)
	);

	initial
	begin
		i_sclk = 1'b0;
		forever #(CLK_PERIOD / 2) i_sclk = ~i_sclk;
	end

	task automatic report_mismatch(input int t, input string sig, input logic [63:0] exp,
		input logic [63:0] got);
		$display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, sig, exp, got);
		test_errs[t]++;
	endtask

	task automatic report_problem(input int t, input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		test_errs[t]++;
	endtask

	task automatic finish_test(input int t);
		if (test_errs[t] == 0)
		begin
			tests_passed++;
			$display("test %-16s ok", test_name[t]);
		end
		else
		begin
			tests_failed++;
			$display("test %-16s failed with %0d errors", test_name[t], test_errs[t]);
		end
	endtask

	task automatic model_word(input stream_pkg::word_t w);
		if (m_sec < `PD_NUM_WIDE && !m_half)
		begin
			m_upper = w;    // first half waits for its partner.
			m_half  = 1'b1;
		end
		else
		begin
			exp_strobe_q.push_back(section_pkg::strobe_t'(1 << m_sec));
			if (m_sec < `PD_NUM_WIDE)
				exp_param_q.push_back({m_upper, w});
			else
				exp_param_q.push_back({{`PD_WORD_W{1'b0}}, w});
			m_half = 1'b0;
			m_cnt  = m_cnt + 1;
			if (m_cnt == SEC_LEN[m_sec])
			begin
				m_cnt = 0;
				if (m_sec == IMAGE)
					model_wait = 1'b1;
				else
					m_sec = m_sec + 1;
			end
		end
	endtask

	task automatic send_word();
		logic [31:0] rnd;
		int          gap;
		rnd = $random(seed);
		gap = int'(rnd[1:0]) % (MAX_GAP + 1);
		if (gap > 0)
		begin
			i_valid = 1'b0;
			repeat (gap) @(negedge i_sclk);
		end
		i_valid = 1'b1;
		i_tdata = $random(seed);
		if (o_ready !== 1'b1)
		begin
			report_problem(cur_test, "input closed before the last image word");
			while (o_ready !== 1'b1) @(negedge i_sclk);
		end
		model_word(i_tdata);    // handshake lands on the coming rising edge.
		@(negedge i_sclk);
	endtask

	task automatic run_pass();
		while (!model_wait)
			send_word();
		i_valid = 1'b0;
	endtask

	task automatic run_inference();
		logic [31:0]          rnd;
		int                   delay;
		int                   hold;
		int                   n;
		logic                 took;
		stream_pkg::predict_t p;
		rnd   = $random(seed);
		delay = 1 + int'(rnd[2:0]);
		hold  = 1 + int'(rnd[5:4]);
		p     = rnd[`PD_PREDICT_W+15:16];
		// words offered while the accelerator computes must not transfer.
		repeat (delay)
		begin
			i_valid = 1'b1;
			i_tdata = $random(seed);
			if (o_ready !== 1'b0) report_mismatch(T_WAIT, "o_ready", 64'(0), 64'(o_ready));
			if (o_valid !== 1'b0) report_mismatch(T_RESULT, "o_valid", 64'(0), 64'(o_valid));
			@(negedge i_sclk);
		end
		if (o_ready !== 1'b0) report_mismatch(T_WAIT, "o_ready", 64'(0), 64'(o_ready));
		i_valid       = 1'b0;
		i_predict_vld = 1'b1;
		i_predict     = p;
		@(negedge i_sclk);
		i_predict_vld = 1'b0;
		if (o_ready !== 1'b1) report_mismatch(T_WAIT, "o_ready", 64'(1), 64'(o_ready));
		n    = 0;
		took = 1'b0;
		while (!took)
		begin
			rnd = $random(seed);
			if (o_valid !== 1'b1) report_mismatch(T_RESULT, "o_valid", 64'(1), 64'(o_valid));
			if (o_tdata !== p) report_mismatch(T_RESULT, "o_tdata", 64'(p), 64'(o_tdata));
			i_ready = (n >= hold) ? rnd[0] : 1'b0;    // held back for the first cycles.
			took    = i_ready;
			n       = n + 1;
			@(negedge i_sclk);
		end
		i_ready = 1'b0;
		if (o_valid !== 1'b0) report_mismatch(T_RESULT, "o_valid", 64'(0), 64'(o_valid));
		m_sec      = IMAGE;
		m_cnt      = 0;
		m_half     = 1'b0;
		model_wait = 1'b0;
	endtask

	task automatic stray_predict();
		logic [31:0] rnd;
		rnd           = $random(seed);
		i_predict_vld = 1'b1;
		i_predict     = rnd[`PD_PREDICT_W-1:0];
		@(negedge i_sclk);
		i_predict_vld = 1'b0;
		repeat (2)
		begin
			if (o_valid !== 1'b0) report_mismatch(T_RESULT, "o_valid", 64'(0), 64'(o_valid));
			@(negedge i_sclk);
		end
	endtask

	// every strobe pulse is matched in order against the model queue.
	always @(negedge i_sclk)
	begin : param_monitor
		section_pkg::strobe_t exp_strobe;
		stream_pkg::param_t   exp_param;
		int                   t;
		if (i_rstp === 1'b0 && o_param_vld !== '0)
		begin
			if ($countones(o_param_vld) != 1)
				report_problem(cur_test, "parameter strobe has more than one bit set");
			for (int s = 0; s < `PD_NUM_SECTIONS; s++)
				if (o_param_vld[s]) seen_cnt[s]++;
			if (reload_phase && o_param_vld !== IMAGE_STROBE)
				report_mismatch(T_RELOAD, "o_param_vld", 64'(IMAGE_STROBE), 64'(o_param_vld));
			if (exp_strobe_q.size() == 0)
				report_problem(cur_test, "parameter output with no word behind it");
			else
			begin
				exp_strobe = exp_strobe_q.pop_front();
				exp_param  = exp_param_q.pop_front();
				t = reload_phase ? T_RELOAD : ((exp_strobe & WIDE_MASK) != '0 ? T_WIDE : T_NARROW);
				if (o_param_vld !== exp_strobe)
					report_mismatch(t, "o_param_vld", 64'(exp_strobe), 64'(o_param_vld));
				if (o_param !== exp_param)
					report_mismatch(t, "o_param", exp_param, o_param);
			end
		end
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		seed          = 32'hfd3504ff;
		i_rstp        = 1'b1;
		i_valid       = 1'b0;
		i_tdata       = '0;
		i_predict_vld = 1'b0;
		i_predict     = '0;
		i_ready       = 1'b0;
		cur_test      = T_RESET;
		reload_phase  = 1'b0;
		tests_passed  = 0;
		tests_failed  = 0;
		m_sec         = 0;
		m_cnt         = 0;
		m_half        = 1'b0;
		model_wait    = 1'b0;
		repeat (RESET_CYCLES)
		begin
			@(negedge i_sclk);
			if (o_ready !== 1'b0) report_mismatch(T_RESET, "o_ready", 64'(0), 64'(o_ready));
			if (o_valid !== 1'b0) report_mismatch(T_RESET, "o_valid", 64'(0), 64'(o_valid));
			if (o_param_vld !== '0)
				report_mismatch(T_RESET, "o_param_vld", 64'(0), 64'(o_param_vld));
		end
		i_rstp = 1'b0;
		@(negedge i_sclk);
		if (o_ready !== 1'b1) report_mismatch(T_RESET, "o_ready", 64'(1), 64'(o_ready));
		finish_test(T_RESET);

		cur_test = T_NARROW;
		run_pass();
		cur_test = T_WAIT;
		run_inference();
		if (exp_param_q.size() != 0)
			report_problem(T_NARROW, "parameters still missing after the full load");
		for (int s = 0; s < `PD_NUM_SECTIONS; s++)
			if (seen_cnt[s] != SEC_LEN[s])
				report_problem((s < `PD_NUM_WIDE) ? T_WIDE : T_NARROW,
					$sformatf("section %0d gave %0d parameters instead of %0d",
					s, seen_cnt[s], SEC_LEN[s]));
		finish_test(T_WIDE);
		finish_test(T_NARROW);

		reload_phase = 1'b1;
		repeat (2)
		begin
			stray_predict();
			cur_test = T_RELOAD;
			run_pass();
			cur_test = T_WAIT;
			run_inference();
			if (exp_param_q.size() != 0)
				report_problem(T_RELOAD, "parameters still missing after an image reload");
		end
		finish_test(T_WAIT);
		finish_test(T_RESULT);
		finish_test(T_RELOAD);

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
